// ==== ramdisk_top.f ====
+incdir+design
design/ramdisk_pkg.sv
design/mem_req_if.sv
design/ramdisk_mapper.sv
design/memory_bus_frontend.sv
design/sram_store.sv
design/ramdisk_top.sv
testbench/tb_ramdisk_top.sv

// ==== Bender.yml ====
package:
  name: ramdisk

sources:
  - include_dirs:
      - design
    files:
      - design/ramdisk_pkg.sv
      - design/mem_req_if.sv
      - design/ramdisk_mapper.sv
      - design/memory_bus_frontend.sv
      - design/sram_store.sv
      - design/ramdisk_top.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - testbench/tb_ramdisk_top.sv

// ==== testbench/tb_ramdisk_top.sv ====
// Testbench for the RAM disk top with random traffic, mapping model, shadow memory and watchdog

`include "ramdisk_cfg.svh"

module tb_ramdisk_top;
    import ramdisk_pkg::*;

    localparam int PERIOD    = 4;
    localparam int MEM_BYTES = `RAMDISK_PAGES * (1 << `RAMDISK_CPU_AW);

    // Requests per phase
    localparam int N_BASIC = 24;
    localparam int N_WIN   = 16;
    localparam int N_STACK = 16;
    localparam int N_RAND  = 200;
    localparam int N_PORTS = 12;
    localparam int REQ_TOTAL = 2 * N_BASIC + 3 * (2 + 3 * N_WIN) + (2 + 3 * N_STACK) + 20
                               + N_RAND + (9 + 3 * N_PORTS);
    // Generous bound on cycles per request under random back-pressure
    localparam int CYCLES_PER_REQ = 32;
    localparam int WATCHDOG_TIME  = (REQ_TOTAL + 16) * CYCLES_PER_REQ * PERIOD;

    logic        clk;
    logic        reset;
    logic        cpu_valid;
    logic        cpu_ready;
    bus_kind_e   cpu_kind;
    logic [15:0] cpu_addr;
    logic [7:0]  cpu_wdata;
    logic        cpu_stack;
    logic        rsp_valid;
    logic        rsp_ready;
    logic [7:0]  rsp_data;

    integer      seed;
    integer      ready_seed;
    string       test_name;

    // Reference model state
    logic [7:0]  ctrl_model;
    logic [7:0]  shadow [MEM_BYTES];
    bit          known  [MEM_BYTES];
    int          exp_q  [$];
    string       name_q [$];
    logic [15:0] addr_list  [$];
    bit          stack_list [$];

    ramdisk_top ramdisk_top_inst (
        .clk       (clk),
        .reset     (reset),
        .cpu_valid (cpu_valid),
        .cpu_ready (cpu_ready),
        .cpu_kind  (cpu_kind),
        .cpu_addr  (cpu_addr),
        .cpu_wdata (cpu_wdata),
        .cpu_stack (cpu_stack),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp_data  (rsp_data)
    );

    always #(PERIOD / 2) clk = ~clk;

    // ------------------------------
    // Model and helpers
    // ------------------------------

    task automatic fail_now(input string what);
        $display("%s", what);
        $display("Some tests failed");
        $fatal(1, "Stopped at first error");
    endtask

    // Stack page first, then the enabled windows, else main RAM
    function automatic int phys_addr(input logic [7:0] ctrl, input logic [15:0] addr,
                                     input logic stack);
        int         page;
        logic [3:0] top;
        top  = addr[15:12];
        page = 0;
        if (stack && ctrl[4]) begin
            page = ctrl[3:2] + 1;
        end else if ((ctrl[6] && top >= 4'h8 && top <= 4'h9)
                     || (ctrl[5] && top >= 4'hA && top <= 4'hD)
                     || (ctrl[7] && top >= 4'hE)) begin
            page = ctrl[1:0] + 1;
        end
        return page * 65536 + addr;
    endfunction

    function automatic logic [7:0] rand_byte();
        int r;
        r = $random(seed);
        return r[7:0];
    endfunction

    // Mostly near window edges and sometimes anywhere
    function automatic logic [15:0] pick_addr();
        logic [15:0] edges [8] = '{16'h0000, 16'h7FFF, 16'h8000, 16'h9FFF,
                                   16'hA000, 16'hDFFF, 16'hE000, 16'hFFFF};
        int          r;
        r = $random(seed);
        if ((r & 3) == 0) begin
            return r[31:16];
        end
        return edges[(r >> 2) & 7] + ((r >> 5) & 7) - 3;
    endfunction

    // One CPU request held until accepted and then applied to the model
    task automatic bus_request(input bus_kind_e kind, input logic [15:0] addr,
                               input logic [7:0] wdata, input logic stack);
        bit taken;
        int phys;
        cpu_valid = 1'b1;
        cpu_kind  = kind;
        cpu_addr  = addr;
        cpu_wdata = wdata;
        cpu_stack = stack;
        taken     = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = cpu_ready;
            @(posedge clk);
        end
        #1;
        cpu_valid = 1'b0;
        if (kind == io_write) begin
            if (addr[7:0] == `RAMDISK_CTRL_PORT) begin
                ctrl_model = wdata;
            end
        end else begin
            phys = phys_addr(ctrl_model, addr, stack);
            if (kind == mem_write) begin
                shadow[phys] = wdata;
                known[phys]  = 1'b1;
            end else begin
                // Bytes never written read as X in the store and are not checked
                exp_q.push_back(known[phys] ? int'(shadow[phys]) : -1);
                name_q.push_back(test_name);
            end
        end
    endtask

    // Upper address byte is don't care for port decode
    task automatic set_ctrl(input logic [7:0] value);
        bus_request(io_write, {rand_byte(), `RAMDISK_CTRL_PORT}, value, 1'b0);
    endtask

    task automatic reread_list();
        for (int i = 0; i < addr_list.size(); i++) begin
            bus_request(mem_read, addr_list[i], 8'h00, stack_list[i]);
        end
    endtask

    // Fresh address list that is written and then read back
    // Stack flag is random when use_stack is set
    task automatic write_then_read(input int n, input bit use_stack);
        logic [15:0] a;
        bit          s;
        addr_list.delete();
        stack_list.delete();
        for (int i = 0; i < n; i++) begin
            a = pick_addr();
            s = use_stack ? rand_byte() % 2 : 1'b0;
            addr_list.push_back(a);
            stack_list.push_back(s);
            bus_request(mem_write, a, rand_byte(), s);
        end
        reread_list();
    endtask

    // ------------------------------
    // Response side
    // ------------------------------

    // Random back-pressure that is mostly ready
    always @(posedge clk) begin
        #1;
        rsp_ready = ($random(ready_seed) & 3) != 0;
    end

    always @(negedge clk) begin : check_rsp
        int    exp;
        string name;
        if (!reset && rsp_valid && rsp_ready) begin
            assert (exp_q.size() != 0) begin
                exp  = exp_q.pop_front();
                name = name_q.pop_front();
                if (exp >= 0) begin
                    assert (rsp_data === exp[7:0]) else
                        fail_now($sformatf("[FAIL] %s: expected %02h, actual %02h",
                                           name, exp[7:0], rsp_data));
                end
            end else begin
                fail_now("A read response arrived with no read outstanding");
            end
        end
    end

    // Watchdog sized from the request count
    initial begin
        #(WATCHDOG_TIME);
        $display("Timeout: run did not finish within %0d time units", WATCHDOG_TIME);
        $display("Some tests failed");
        $fatal(1, "Watchdog expired");
    end

    // ------------------------------
    // Test sequence
    // ------------------------------

    initial begin
        logic [7:0]  rp;
        logic [7:0]  sp;
        logic [7:0]  base;
        logic [7:0]  port;
        logic [15:0] a;
        int          r;
        seed       = 76619;
        ready_seed = 76619;
        clk        = 1'b0;
        reset      = 1'b1;
        cpu_valid  = 1'b0;
        cpu_kind   = mem_read;
        cpu_addr   = '0;
        cpu_wdata  = '0;
        cpu_stack  = 1'b0;
        rsp_ready  = 1'b0;
        ctrl_model = 8'h00;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;

        // Empty stage and no response right after reset
        test_name = "reset_state";
        assert (cpu_ready === 1'b1) else
            fail_now($sformatf("[FAIL] %s: expected cpu_ready 1, actual %b",
                               test_name, cpu_ready));
        assert (rsp_valid === 1'b0) else
            fail_now($sformatf("[FAIL] %s: expected rsp_valid 0, actual %b",
                               test_name, rsp_valid));

        // Control register is zero so all accesses stay in main RAM
        test_name = "main_ram_after_reset";
        write_then_read(N_BASIC, 1'b1);

        // One window at a time with a random RAM page and then back to main RAM
        test_name = "window_select";
        for (int w = 0; w < 3; w++) begin
            rp = rand_byte() & 8'h03;
            set_ctrl((8'h20 << w) | rp);
            write_then_read(N_WIN, 1'b0);
            set_ctrl(8'h00);
            reread_list();
        end

        // Stack page differs from RAM page and wins inside windows
        test_name = "stack_select";
        rp = rand_byte() & 8'h03;
        sp = (rp + 1 + (rand_byte() % 3)) & 8'h03;
        set_ctrl(8'hF0 | (sp << 2) | rp);
        write_then_read(N_STACK, 1'b1);
        set_ctrl(8'hE0 | (sp << 2) | rp);
        reread_list();

        // Same CPU address with one distinct byte per page
        test_name = "page_separation";
        a    = 16'hA000 + (pick_addr() & 16'h3FFF);
        base = rand_byte();
        for (int p = 0; p < 4; p++) begin
            set_ctrl(8'h20 | p[7:0]);
            bus_request(mem_write, a, base + p * 37, 1'b0);
        end
        set_ctrl(8'h00);
        bus_request(mem_write, a, ~base, 1'b0);
        for (int p = 0; p < 4; p++) begin
            set_ctrl(8'h20 | p[7:0]);
            bus_request(mem_read, a, 8'h00, 1'b0);
        end
        set_ctrl(8'h00);
        bus_request(mem_read, a, 8'h00, 1'b0);

        // Mixed traffic with reads mostly at written addresses
        test_name = "random_backpressure";
        addr_list.delete();
        stack_list.delete();
        for (int i = 0; i < N_RAND; i++) begin
            r = $random(seed) & 7;
            if (r == 0) begin
                set_ctrl(rand_byte());
            end else if (r <= 3) begin
                a = pick_addr();
                addr_list.push_back(a);
                stack_list.push_back(rand_byte() % 2);
                bus_request(mem_write, a, rand_byte(), stack_list[$]);
            end else if (addr_list.size() != 0) begin
                r = (rand_byte() * 256 + rand_byte()) % addr_list.size();
                bus_request(mem_read, addr_list[r], 8'h00, stack_list[r]);
            end else begin
                bus_request(mem_read, pick_addr(), 8'h00, rand_byte() % 2);
            end
        end

        // Writes to other ports must not touch the mapping
        test_name = "other_ports_ignored";
        set_ctrl(8'hE0 | (rand_byte() & 8'h1F));
        write_then_read(N_PORTS, 1'b1);
        for (int i = 0; i < 8; i++) begin
            port = rand_byte();
            if (port == `RAMDISK_CTRL_PORT) begin
                port = port + 1;
            end
            bus_request(io_write, {rand_byte(), port}, rand_byte(), 1'b0);
        end
        reread_list();

        // Drain outstanding reads and then watch for stray responses
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (8) @(posedge clk);
        $display("All tests passed");
        $finish;
    end

endmodule

// ==== design/ramdisk_top.sv ====
// RAM disk top level: bus front end beside the backing store

`include "ramdisk_cfg.svh"

module ramdisk_top (
    input  logic                       clk,
    input  logic                       reset,
    // ------------------------------
    // CPU request channel
    // ------------------------------
    input  logic                       cpu_valid,
    output logic                       cpu_ready,
    input  ramdisk_pkg::bus_kind_e     cpu_kind,
    input  logic [`RAMDISK_CPU_AW-1:0] cpu_addr,
    input  logic [7:0]                 cpu_wdata,
    input  logic                       cpu_stack,
    // ------------------------------
    // Read response channel
    // ------------------------------
    output logic                       rsp_valid,
    input  logic                       rsp_ready,
    output logic [7:0]                 rsp_data
);

    // Physical request path between front end and store
    mem_req_if mem_if ();

    // CPU stage and RAM disk mapping
    memory_bus_frontend frontend_inst (
        .clk       (clk),
        .reset     (reset),
        .cpu_valid (cpu_valid),
        .cpu_ready (cpu_ready),
        .cpu_kind  (cpu_kind),
        .cpu_addr  (cpu_addr),
        .cpu_wdata (cpu_wdata),
        .cpu_stack (cpu_stack),
        .mem       (mem_if.master)
    );

    // Backing store for main RAM and disk pages
    sram_store store_inst (
        .clk   (clk),
        .reset (reset),
        .mem   (mem_if.slave)
    );

    // Responses go straight back to the CPU side
    assign rsp_valid        = mem_if.rsp_valid;
    assign rsp_data         = mem_if.rsp_data;
    assign mem_if.rsp_ready = rsp_ready;

endmodule

// ==== design/sram_store.sv ====
// On-chip byte store with registered read response and back-pressure

`include "ramdisk_cfg.svh"

module sram_store (
    input  logic     clk,
    input  logic     reset,
    mem_req_if.slave mem
);
    // Main RAM plus four disk pages of 64 KiB
    localparam int DEPTH = `RAMDISK_PAGES * (1 << `RAMDISK_CPU_AW);

    logic [7:0] mem_array [DEPTH];

    logic       req_fire;
    logic       rd_fire;

    // ------------------------------
    // Request side
    // ------------------------------

    // A response still waiting for its handshake blocks new requests
    assign mem.req_ready = !mem.rsp_valid || mem.rsp_ready;
    assign req_fire      = mem.req_valid && mem.req_ready;
    assign rd_fire       = req_fire && !mem.req_write;

    // Writes land on the transfer edge
    always_ff @(posedge clk) begin
        if (req_fire && mem.req_write) begin
            mem_array[mem.req_addr] <= mem.req_wdata;
        end
    end

    // ------------------------------
    // Read response register
    // ------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            mem.rsp_valid <= 1'b0;
        end else if (rd_fire) begin
            mem.rsp_valid <= 1'b1;
        end else if (mem.rsp_ready) begin
            mem.rsp_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_fire) begin
            mem.rsp_data <= mem_array[mem.req_addr];
        end
    end

    // Stalled response holds its data
    assert property (@(posedge clk) disable iff (reset)
        mem.rsp_valid && !mem.rsp_ready |=> mem.rsp_valid && $stable(mem.rsp_data));

endmodule

// ==== design/memory_bus_frontend.sv ====
// CPU bus front end: request stage, control port decode, physical address

`include "ramdisk_cfg.svh"

module memory_bus_frontend (
    input  logic                       clk,
    input  logic                       reset,
    // CPU request channel
    input  logic                       cpu_valid,
    output logic                       cpu_ready,
    input  ramdisk_pkg::bus_kind_e     cpu_kind,
    input  logic [`RAMDISK_CPU_AW-1:0] cpu_addr,
    input  logic [7:0]                 cpu_wdata,
    input  logic                       cpu_stack,
    // Physical request to the store
    mem_req_if.master                  mem
);
    import ramdisk_pkg::*;

    // Bits above the CPU address hold the physical page number
    localparam int PAGE_W = `RAMDISK_PHYS_AW - `RAMDISK_CPU_AW;

    // Request stage
    logic                       stg_valid;
    bus_kind_e                  stg_kind;
    logic [`RAMDISK_CPU_AW-1:0] stg_addr;
    logic [7:0]                 stg_wdata;
    logic                       stg_stack;

    logic                       cpu_fire;
    logic                       stg_is_io;
    logic                       stg_leave;

    // Control port write towards the mapper
    logic                       ctrl_write;
    kvaz_ctrl_u                 ctrl_byte;

    // Mapper result
    logic                       disk_sel;
    logic [1:0]                 page;
    logic [PAGE_W-1:0]          page_num;

    // ------------------------------
    // Request stage
    // ------------------------------

    // I/O writes leave at once, memory requests wait for the store
    assign stg_is_io = (stg_kind == io_write);
    assign stg_leave = stg_valid && (stg_is_io || mem.req_ready);
    assign cpu_ready = !stg_valid || stg_leave;
    assign cpu_fire  = cpu_valid && cpu_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            stg_valid <= 1'b0;
        end else if (cpu_fire) begin
            stg_valid <= 1'b1;
        end else if (stg_leave) begin
            stg_valid <= 1'b0;
        end
    end

    // Payload follows the valid bit
    always_ff @(posedge clk) begin
        if (cpu_fire) begin
            stg_kind  <= cpu_kind;
            stg_addr  <= cpu_addr;
            stg_wdata <= cpu_wdata;
            stg_stack <= cpu_stack;
        end
    end

    // ------------------------------
    // Control port and mapping
    // ------------------------------

    // Port number is in the low address byte, other ports are dropped
    assign ctrl_write    = stg_valid && stg_is_io
                           && (stg_addr[7:0] == `RAMDISK_CTRL_PORT);
    assign ctrl_byte.raw = stg_wdata;

    ramdisk_mapper mapper_inst (
        .clk        (clk),
        .reset      (reset),
        .ctrl_write (ctrl_write),
        .ctrl_data  (ctrl_byte.raw),
        .address    (stg_addr),
        .stack      (stg_stack),
        .disk_sel   (disk_sel),
        .page       (page)
    );

    // Disk pages sit above main RAM, so page 0 of the disk is physical page 1
    assign page_num = disk_sel ? PAGE_W'(page) + 1'b1 : '0;

    // ------------------------------
    // Store request
    // ------------------------------

    assign mem.req_valid = stg_valid && !stg_is_io;
    assign mem.req_write = (stg_kind == mem_write);
    assign mem.req_addr  = {page_num, stg_addr};
    assign mem.req_wdata = stg_wdata;

    // Held request keeps its payload and mapping until taken
    assert property (@(posedge clk) disable iff (reset)
        mem.req_valid && !mem.req_ready |=>
            mem.req_valid && $stable(mem.req_addr)
            && $stable(mem.req_write) && $stable(mem.req_wdata));

endmodule

// ==== design/ramdisk_mapper.sv ====
// Control register and window and stack page decode of the RAM disk mapper

`include "ramdisk_cfg.svh"

module ramdisk_mapper (
    input  logic                       clk,
    input  logic                       reset,
    // Control register load
    input  logic                       ctrl_write,
    input  logic [7:0]                 ctrl_data,
    // Access to be mapped
    input  logic [`RAMDISK_CPU_AW-1:0] address,
    input  logic                       stack,
    // Mapping result
    output logic                       disk_sel,
    output logic [1:0]                 page
);
    import ramdisk_pkg::*;

    // Control register loaded as a raw byte and decoded as fields
    kvaz_ctrl_u ctrl;

    // Top nibble of the CPU address picks the window
    logic [3:0] adsel;
    logic       win_89;
    logic       win_ad;
    logic       win_ef;
    logic       ram_sel;
    logic       stack_sel;

    // ------------------------------
    // Control register
    // ------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            ctrl.raw <= '0;
        end else if (ctrl_write) begin
            ctrl.raw <= ctrl_data;
        end
    end

    // ------------------------------
    // Window and stack decode
    // ------------------------------

    assign adsel = address[`RAMDISK_CPU_AW-1 -: 4];

    always_comb begin
        // Each window only counts when its enable bit is set
        win_89 = (adsel inside {[4'h8:4'h9]}) && ctrl.fields.win_89_en;
        win_ad = (adsel inside {[4'hA:4'hD]}) && ctrl.fields.win_ad_en;
        win_ef = (adsel inside {[4'hE:4'hF]}) && ctrl.fields.win_ef_en;
        ram_sel = win_89 || win_ad || win_ef;

        // Stack select wins over any window
        stack_sel = stack && ctrl.fields.stack_en;

        disk_sel = stack_sel || ram_sel;
        if (stack_sel) begin
            page = ctrl.fields.stack_page;
        end else if (ram_sel) begin
            page = ctrl.fields.ram_page;
        end else begin
            page = 2'b00;
        end
    end

    // ------------------------------
    // Checks
    // ------------------------------

    // Below 8000 only a stack access can reach a disk page
    assert property (@(posedge clk) disable iff (reset)
        !stack && !address[`RAMDISK_CPU_AW-1] |-> !disk_sel && (page == 2'b00));

endmodule

// ==== design/mem_req_if.sv ====
// Physical memory request and read response interface

`include "ramdisk_cfg.svh"

interface mem_req_if;

    // Request channel, front end to store
    logic                        req_valid;
    logic                        req_ready;
    logic                        req_write;
    logic [`RAMDISK_PHYS_AW-1:0] req_addr;
    logic [7:0]                  req_wdata;

    // Read response channel, store to CPU side
    logic                        rsp_valid;
    logic                        rsp_ready;
    logic [7:0]                  rsp_data;

    // Front end issues requests
    modport master (
        output req_valid,
        output req_write,
        output req_addr,
        output req_wdata,
        input  req_ready
    );

    // Store takes requests and returns read data
    modport slave (
        input  req_valid,
        input  req_write,
        input  req_addr,
        input  req_wdata,
        output req_ready,
        output rsp_valid,
        output rsp_data,
        input  rsp_ready
    );

endinterface

// ==== design/ramdisk_pkg.sv ====
// RAM disk package: bus request kind and control register union

package ramdisk_pkg;

    // ------------------------------
    // CPU bus request kinds
    // ------------------------------

    // Only memory reads produce a response
    typedef enum logic [1:0] {
        mem_read  = 2'b00,
        mem_write = 2'b01,
        io_write  = 2'b10
    } bus_kind_e;

    // ------------------------------
    // Control register at port 0x10
    // ------------------------------

    // Bit layout, top bit first
    typedef struct packed {
        logic       win_ef_en;   // E000-FFFF goes to RAM page
        logic       win_89_en;   // 8000-9FFF goes to RAM page
        logic       win_ad_en;   // A000-DFFF goes to RAM page
        logic       stack_en;    // Stack accesses go to stack page
        logic [1:0] stack_page;
        logic [1:0] ram_page;
    } kvaz_ctrl_fields_t;

    // Raw byte as written by the CPU, fields as decoded by the mapper
    typedef union packed {
        logic [7:0]        raw;
        kvaz_ctrl_fields_t fields;
    } kvaz_ctrl_u;

endpackage

// ==== design/ramdisk_cfg.svh ====
// RAM disk configuration constants: control port, address widths, page count

`ifndef RAMDISK_CFG_SVH
`define RAMDISK_CFG_SVH

// ------------------------------
// I/O map
// ------------------------------

// Port number of the RAM disk control register
`define RAMDISK_CTRL_PORT 8'h10

// ------------------------------
// Address space
// ------------------------------

// CPU side address width, one 64 KiB space
`define RAMDISK_CPU_AW 16

// Physical address width, page number above the CPU address
`define RAMDISK_PHYS_AW 19

// Pages in the backing store
// Page 0 is main RAM, pages 1 to 4 hold the disk
`define RAMDISK_PAGES 5

`endif
